// ==== Bender.yml ====
package:
  name: uc_fabric

sources:
  # RTL, package first
  - files:
      - hdl/fabric_pkg.sv
      - hdl/ahb_addr_decode.sv
      - hdl/ccm_sram.sv
      - hdl/soc_ifc_regs.sv
      - hdl/uc_fabric_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_uc_fabric.sv

// ==== hdl/ahb_addr_decode.sv ====
// AHB-lite address decoder with ICCM disable, error responses and response mux
`timescale 1ns/1ns

module ahb_addr_decode
    import fabric_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  ahb_req_t  ahb_req_i,
    input  ahb_resp_t ccm_resp_i,
    input  ahb_resp_t soc_resp_i,
    input  logic      iccm_lock_i,
    output ahb_req_t  dec_req_o,
    output logic      ccm_sel_o,
    output logic      soc_sel_o,
    output ahb_resp_t ahb_resp_o,
    output logic      iccm_axs_blocked_o
);

    logic     addr_phase;     // Transfer accepted this cycle
    logic     hit_dccm;
    logic     hit_iccm;
    logic     hit_soc;
    logic     ccm_go;
    logic     soc_go;
    logic     blk_go;
    logic     err_go;

    ahb_req_t req_q;          // Address phase copy
    logic     ccm_sel_q;
    logic     soc_sel_q;
    logic     err1_q;         // First error cycle, hready low
    logic     err2_q;         // Second error cycle, hready high
    logic     blk_q;

    // ======================================================================
    // Address phase
    // ======================================================================
    assign addr_phase = (ahb_req_i.htrans == HTRANS_NONSEQ) && ahb_resp_o.hready;

    always_comb begin
        hit_dccm = win_hit(ahb_req_i.haddr, DCCM_BASE, CCM_WIN_MASK);
        hit_iccm = win_hit(ahb_req_i.haddr, ICCM_BASE, CCM_WIN_MASK);
        hit_soc  = win_hit(ahb_req_i.haddr, SOC_IFC_BASE, SOC_IFC_WIN_MASK);
    end

    // Both DMA windows land on the same memory, lock only disables ICCM
    assign ccm_go = addr_phase && (hit_dccm || (hit_iccm && !iccm_lock_i));
    assign soc_go = addr_phase && hit_soc;
    assign blk_go = addr_phase && hit_iccm && iccm_lock_i;
    assign err_go = addr_phase && !ccm_go && !soc_go;   // Unmapped or blocked

    // Request copy for the data phase
    always_ff @(posedge clk) begin
        if (addr_phase) begin
            req_q <= ahb_req_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ccm_sel_q <= 1'b0;
            soc_sel_q <= 1'b0;
            err1_q    <= 1'b0;
            err2_q    <= 1'b0;
            blk_q     <= 1'b0;
        end else begin
            ccm_sel_q <= ccm_go;
            soc_sel_q <= soc_go;
            err1_q    <= err_go;
            err2_q    <= err1_q;
            blk_q     <= blk_go;
        end
    end

    // ======================================================================
    // Data phase
    // ======================================================================
    always_comb begin
        dec_req_o        = req_q;
        dec_req_o.hwdata = ahb_req_i.hwdata;   // Write data follows the address
    end

    assign ccm_sel_o          = ccm_sel_q;
    assign soc_sel_o          = soc_sel_q;
    assign iccm_axs_blocked_o = blk_q;         // Pulses in the first error cycle

    // Two cycle ERROR response, otherwise the selected responder
    always_comb begin
        ahb_resp_o = '{hrdata: '0, hready: 1'b1, hresp: HRESP_OKAY};
        if (err1_q) begin
            ahb_resp_o.hready = 1'b0;
            ahb_resp_o.hresp  = HRESP_ERROR;
        end else if (err2_q) begin
            ahb_resp_o.hresp  = HRESP_ERROR;
        end else if (ccm_sel_q) begin
            ahb_resp_o = ccm_resp_i;
        end else if (soc_sel_q) begin
            ahb_resp_o = soc_resp_i;
        end
    end

endmodule

// ==== hdl/ccm_sram.sv ====
// Single-port memory shared by the ICCM and DCCM DMA windows
`timescale 1ns/1ns

module ccm_sram
    import fabric_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  ahb_req_t  dec_req_i,
    input  logic      sel_i,
    output ahb_resp_t resp_o
);

    logic [AHB_DATA_W-1:0] mem [CCM_WORDS];
    logic [CCM_WORDS-1:0]  word_vld;   // Word written since reset
    logic [CCM_AW-1:0]     idx;
    logic                  wr_en;

    // Address bits 10:3, so both windows alias the same array
    assign idx   = dec_req_i.haddr[CCM_IDX_LSB +: CCM_AW];
    assign wr_en = sel_i && dec_req_i.hwrite;

    // ======================================================================
    // Write port, takes effect at the end of the data phase
    // ======================================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[idx] <= dec_req_i.hwdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            word_vld <= '0;
        end else if (wr_en) begin
            word_vld[idx] <= 1'b1;
        end
    end

    // ======================================================================
    // Read port
    // ======================================================================
    // Address was registered by the decoder one cycle earlier
    // so data lands in the data phase
    always_comb begin
        resp_o.hrdata = word_vld[idx] ? mem[idx] : '0;   // Unwritten words read zero
        resp_o.hready = 1'b1;                             // No wait states
        resp_o.hresp  = HRESP_OKAY;
    end

endmodule

// ==== hdl/fabric_pkg.sv ====
// AHB-lite bus types, address map, register offsets and interrupt vector numbers
package fabric_pkg;

    // ======================================================================
    // Bus widths and transfer encodings
    // ======================================================================
    localparam int unsigned AHB_ADDR_W = 32;
    localparam int unsigned AHB_DATA_W = 64;
    localparam int unsigned AHB_SIZE_W = 3;

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    // Initiator side, address phase fields plus write data
    typedef struct packed {
        logic [AHB_ADDR_W-1:0] haddr;
        logic [1:0]            htrans;
        logic                  hwrite;
        logic [AHB_SIZE_W-1:0] hsize;
        logic [AHB_DATA_W-1:0] hwdata;   // Valid in the data phase
    } ahb_req_t;

    // Responder side
    typedef struct packed {
        logic [AHB_DATA_W-1:0] hrdata;
        logic                  hready;
        logic                  hresp;
    } ahb_resp_t;

    // ======================================================================
    // Address map
    // ======================================================================
    localparam int unsigned CCM_AW      = 8;             // 256 words of 64 bits
    localparam int unsigned CCM_WORDS   = 2 ** CCM_AW;
    localparam int unsigned CCM_IDX_LSB = 3;             // Byte offset within a word

    localparam logic [AHB_ADDR_W-1:0] DCCM_BASE    = 32'h5000_0000;
    localparam logic [AHB_ADDR_W-1:0] ICCM_BASE    = 32'h4000_0000;
    localparam logic [AHB_ADDR_W-1:0] CCM_WIN_MASK = 32'h0000_07FF;

    localparam logic [AHB_ADDR_W-1:0] SOC_IFC_BASE     = 32'h3003_0000;
    localparam logic [AHB_ADDR_W-1:0] SOC_IFC_WIN_MASK = 32'h0000_00FF;

    // ======================================================================
    // SoC interface registers
    // ======================================================================
    localparam int unsigned SOC_IFC_OFS_W = 8;
    localparam int unsigned GENERIC_W     = 64;

    localparam logic [SOC_IFC_OFS_W-1:0] REG_GENERIC_OUT  = 8'h00;
    localparam logic [SOC_IFC_OFS_W-1:0] REG_ICCM_LOCK    = 8'h08;   // Bit 0, set only
    localparam logic [SOC_IFC_OFS_W-1:0] REG_ERROR_STATUS = 8'h10;   // Bit 0, W1C
    localparam logic [SOC_IFC_OFS_W-1:0] REG_NOTIF_STATUS = 8'h18;   // Bit 0, W1C
    localparam logic [SOC_IFC_OFS_W-1:0] REG_DOORBELL     = 8'h20;
    localparam logic [SOC_IFC_OFS_W-1:0] REG_GENERIC_IN   = 8'h28;

    // ======================================================================
    // Processor interrupt vector
    // ======================================================================
    // Vector 0 is reserved, so vector N lands on intr bit N-1
    localparam int unsigned NUM_INTR               = 31;
    localparam int unsigned INTR_VEC_SOC_IFC_ERROR = 19;
    localparam int unsigned INTR_VEC_SOC_IFC_NOTIF = 20;

    // Window match on base address and size mask
    function automatic logic win_hit(
        input logic [AHB_ADDR_W-1:0] addr,
        input logic [AHB_ADDR_W-1:0] base,
        input logic [AHB_ADDR_W-1:0] mask
    );
        return (addr & ~mask) == base;
    endfunction

endpackage

// ==== hdl/soc_ifc_regs.sv ====
// SoC interface registers with ICCM lock, generic wires, doorbell and interrupts
`timescale 1ns/1ns

module soc_ifc_regs
    import fabric_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  ahb_req_t             dec_req_i,
    input  logic                 sel_i,
    input  logic                 iccm_axs_blocked_i,
    input  logic [GENERIC_W-1:0] generic_input_i,
    output ahb_resp_t            resp_o,
    output logic [GENERIC_W-1:0] generic_output_o,
    output logic                 iccm_lock_o,
    output logic                 error_intr_o,
    output logic                 notif_intr_o
);

    logic [SOC_IFC_OFS_W-1:0] ofs;
    logic                     wr;
    logic                     wr_gen;
    logic                     wr_lock;
    logic                     wr_err;
    logic                     wr_notif;
    logic                     wr_bell;

    logic [GENERIC_W-1:0]     gen_out_q;
    logic                     lock_q;
    logic                     err_sts_q;
    logic                     notif_sts_q;
    logic [AHB_DATA_W-1:0]    rdata;

    // ======================================================================
    // Write decode
    // ======================================================================
    assign ofs = dec_req_i.haddr[SOC_IFC_OFS_W-1:0];
    assign wr  = sel_i && dec_req_i.hwrite;

    assign wr_gen   = wr && (ofs == REG_GENERIC_OUT);
    assign wr_lock  = wr && (ofs == REG_ICCM_LOCK);
    assign wr_err   = wr && (ofs == REG_ERROR_STATUS);
    assign wr_notif = wr && (ofs == REG_NOTIF_STATUS);
    assign wr_bell  = wr && (ofs == REG_DOORBELL);   // Any data rings it

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gen_out_q   <= '0;
            lock_q      <= 1'b0;
            err_sts_q   <= 1'b0;
            notif_sts_q <= 1'b0;
        end else begin
            if (wr_gen) begin
                gen_out_q <= dec_req_i.hwdata;
            end

            // Lock sticks until reset
            if (wr_lock && dec_req_i.hwdata[0]) begin
                lock_q <= 1'b1;
            end

            // Hardware set wins over a clear in the same cycle
            if (iccm_axs_blocked_i) begin
                err_sts_q <= 1'b1;
            end else if (wr_err && dec_req_i.hwdata[0]) begin
                err_sts_q <= 1'b0;
            end

            if (wr_bell) begin
                notif_sts_q <= 1'b1;
            end else if (wr_notif && dec_req_i.hwdata[0]) begin
                notif_sts_q <= 1'b0;
            end
        end
    end

    // ======================================================================
    // Read mux and outputs
    // ======================================================================
    always_comb begin
        rdata = '0;
        case (ofs)
            REG_GENERIC_OUT:  rdata    = gen_out_q;
            REG_ICCM_LOCK:    rdata[0] = lock_q;
            REG_ERROR_STATUS: rdata[0] = err_sts_q;
            REG_NOTIF_STATUS: rdata[0] = notif_sts_q;
            REG_GENERIC_IN:   rdata    = generic_input_i;
            default:          rdata    = '0;   // Doorbell and holes
        endcase
    end

    always_comb begin
        resp_o.hrdata = rdata;
        resp_o.hready = 1'b1;
        resp_o.hresp  = HRESP_OKAY;   // Holes answer OKAY too
    end

    assign generic_output_o = gen_out_q;
    assign iccm_lock_o      = lock_q;
    assign error_intr_o     = err_sts_q;
    assign notif_intr_o     = notif_sts_q;

endmodule

// ==== hdl/uc_fabric_top.sv ====
// uC fabric top level with decoder, shared CCM, SoC interface and interrupt vector
`timescale 1ns/1ns

module uc_fabric_top
    import fabric_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  ahb_req_t             ahb_req_i,
    input  logic [GENERIC_W-1:0] generic_input_i,
    output ahb_resp_t            ahb_resp_o,
    output logic [GENERIC_W-1:0] generic_output_o,
    output logic [NUM_INTR-1:0]  intr_o
);

    ahb_req_t  dec_req;
    logic      ccm_sel;
    logic      soc_sel;
    ahb_resp_t ccm_resp;
    ahb_resp_t soc_resp;
    logic      iccm_lock;
    logic      iccm_axs_blocked;
    logic      soc_ifc_error_intr;
    logic      soc_ifc_notif_intr;

    // ======================================================================
    // Bus decode
    // ======================================================================
    ahb_addr_decode u_decode (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .ahb_req_i          (ahb_req_i),
        .ccm_resp_i         (ccm_resp),
        .soc_resp_i         (soc_resp),
        .iccm_lock_i        (iccm_lock),
        .dec_req_o          (dec_req),
        .ccm_sel_o          (ccm_sel),
        .soc_sel_o          (soc_sel),
        .ahb_resp_o         (ahb_resp_o),
        .iccm_axs_blocked_o (iccm_axs_blocked)
    );

    // ======================================================================
    // Responders
    // ======================================================================
    ccm_sram u_ccm (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dec_req_i (dec_req),
        .sel_i   (ccm_sel),           // ICCM and DCCM hits share one select
        .resp_o  (ccm_resp)
    );

    soc_ifc_regs u_soc_ifc (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .dec_req_i          (dec_req),
        .sel_i              (soc_sel),
        .iccm_axs_blocked_i (iccm_axs_blocked),
        .generic_input_i    (generic_input_i),
        .resp_o             (soc_resp),
        .generic_output_o   (generic_output_o),
        .iccm_lock_o        (iccm_lock),
        .error_intr_o       (soc_ifc_error_intr),
        .notif_intr_o       (soc_ifc_notif_intr)
    );

    // Bit 0 drives vector 1, unused sources stay low
    always_comb begin
        intr_o                             = '0;
        intr_o[INTR_VEC_SOC_IFC_ERROR - 1] = soc_ifc_error_intr;
        intr_o[INTR_VEC_SOC_IFC_NOTIF - 1] = soc_ifc_notif_intr;
    end

endmodule

// ==== sources.f ====
+incdir+testbench
hdl/fabric_pkg.sv
hdl/ahb_addr_decode.sv
hdl/ccm_sram.sv
hdl/soc_ifc_regs.sv
hdl/uc_fabric_top.sv
testbench/tb_uc_fabric.sv

// ==== testbench/tb_ahb_tasks.svh ====
// AHB-lite transfer result struct, single transfer read and write tasks, Fibonacci LFSR
`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

// ======================================================================
// Pseudo random source
// ======================================================================
localparam logic [15:0] LFSR_SEED = 16'd66;

logic [15:0] lfsr_q = LFSR_SEED;

// x^16 + x^14 + x^13 + x^11 + 1, one step per bit handed out
function automatic logic [63:0] lfsr_next_bits(input int unsigned nbits);
    logic [63:0] val;
    logic        fb;
    int unsigned i;
    val = '0;
    for (i = 0; i < nbits; i++) begin
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        val    = {val[62:0], fb};
    end
    return val;
endfunction

// ======================================================================
// Single transfers
// ======================================================================
typedef struct packed {
    logic [AHB_DATA_W-1:0] rdata;
    logic                  hresp_first;   // hresp in the first data phase cycle
    logic                  hresp_last;    // hresp when hready came back
    logic [7:0]            cycles;        // Data phase length
} xfer_result_t;

task automatic bus_transfer(
    input  logic [AHB_ADDR_W-1:0] addr,
    input  logic                  write,
    input  logic [AHB_DATA_W-1:0] wdata,
    output xfer_result_t          res
);
    @(posedge clk);
    #DRV_DLY;
    ahb_req.haddr  = addr;
    ahb_req.htrans = HTRANS_NONSEQ;
    ahb_req.hwrite = write;
    ahb_req.hsize  = 3'b011;              // 64 bit beat
    ahb_req.hwdata = '0;
    @(negedge clk);
    while (!ahb_resp.hready) begin        // Address held while stalled
        @(negedge clk);
    end

    // Data phase begins on the accepting edge
    @(posedge clk);
    #DRV_DLY;
    ahb_req.htrans = HTRANS_IDLE;
    ahb_req.hwdata = write ? wdata : '0;
    @(negedge clk);
    res.cycles      = 8'd1;
    res.hresp_first = ahb_resp.hresp;
    while (!ahb_resp.hready) begin
        @(negedge clk);
        res.cycles++;
    end
    res.rdata      = ahb_resp.hrdata;
    res.hresp_last = ahb_resp.hresp;
endtask

task automatic write_word(input logic [AHB_ADDR_W-1:0] addr,
                          input logic [AHB_DATA_W-1:0] data, output xfer_result_t res);
    bus_transfer(addr, 1'b1, data, res);
endtask

task automatic read_word(input logic [AHB_ADDR_W-1:0] addr, output xfer_result_t res);
    bus_transfer(addr, 1'b0, '0, res);
endtask

`endif

// ==== testbench/tb_uc_fabric.sv ====
// uC fabric top testbench with clock, reset, stimulus sequence, assertions and timeout
`timescale 1ns/1ns

module tb_uc_fabric
    import fabric_pkg::*;
();

    localparam int unsigned CLK_HALF       = 20;     // 40 ns period
    localparam int unsigned DRV_DLY        = 5;
    localparam int unsigned TIMEOUT_CYCLES = 2000;
    localparam int unsigned NUM_WORDS      = 8;
    localparam int unsigned ERR_BIT        = INTR_VEC_SOC_IFC_ERROR - 1;
    localparam int unsigned NOTIF_BIT      = INTR_VEC_SOC_IFC_NOTIF - 1;
    localparam logic [NUM_INTR-1:0] INTR_USED =
        (NUM_INTR'(1) << ERR_BIT) | (NUM_INTR'(1) << NOTIF_BIT);

    logic                  clk;
    logic                  rst_n;
    ahb_req_t              ahb_req;
    ahb_resp_t             ahb_resp;
    logic [GENERIC_W-1:0]  generic_in;
    logic [GENERIC_W-1:0]  generic_out;
    logic [NUM_INTR-1:0]   intr;
    logic [AHB_DATA_W-1:0] mem_model [CCM_WORDS];   // Expected shared memory
    int unsigned           cycle_cnt;

    `include "tb_ahb_tasks.svh"

    uc_fabric_top DUT (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .ahb_req_i        (ahb_req),
        .generic_input_i  (generic_in),
        .ahb_resp_o       (ahb_resp),
        .generic_output_o (generic_out),
        .intr_o           (intr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    // ======================================================================
    // Protocol and interrupt vector assertions
    // ======================================================================
    a_intr_unused: assert property (@(negedge clk) (intr & ~INTR_USED) == '0)
        else stop_on_error($sformatf("unassigned interrupt bit high, intr_o=%h", intr));

    a_err_shape: assert property (@(negedge clk) disable iff (!rst_n)
        (ahb_resp.hresp && !ahb_resp.hready) |=> (ahb_resp.hresp && ahb_resp.hready))
        else stop_on_error("first ERROR cycle not followed by the completing one");

    // Word index sits on address bits 10:3 in both memory windows
    function automatic logic [AHB_ADDR_W-1:0] dccm_addr(input logic [CCM_AW-1:0] idx);
        return DCCM_BASE | AHB_ADDR_W'({idx, 3'b000});
    endfunction

    function automatic logic [AHB_ADDR_W-1:0] iccm_addr(input logic [CCM_AW-1:0] idx);
        return ICCM_BASE | AHB_ADDR_W'({idx, 3'b000});
    endfunction

    function automatic logic [AHB_ADDR_W-1:0] reg_addr(input logic [7:0] ofs);
        return SOC_IFC_BASE | AHB_ADDR_W'(ofs);
    endfunction

    task automatic store_and_check(input logic [AHB_ADDR_W-1:0] addr,
                                   input logic [AHB_DATA_W-1:0] data, input string what);
        xfer_result_t res;
        write_word(addr, data, res);
        assert (!res.hresp_last && res.cycles == 8'd1)
            else stop_on_error($sformatf("%s write at %h not OKAY in one cycle", what, addr));
    endtask

    task automatic load_and_compare(input logic [AHB_ADDR_W-1:0] addr,
                                    input logic [AHB_DATA_W-1:0] exp, input string what);
        xfer_result_t res;
        read_word(addr, res);
        assert (!res.hresp_last && res.cycles == 8'd1)
            else stop_on_error($sformatf("%s read at %h not OKAY in one cycle", what, addr));
        assert (res.rdata === exp)
            else stop_on_error($sformatf("%s read at %h gave %h, expected %h",
                                         what, addr, res.rdata, exp));
    endtask

    task automatic expect_bus_error(input logic [AHB_ADDR_W-1:0] addr, input logic write,
                                    input string what);
        xfer_result_t res;
        if (write) begin
            write_word(addr, lfsr_next_bits(AHB_DATA_W), res);
        end else begin
            read_word(addr, res);
        end
        assert (res.cycles == 8'd2 && res.hresp_first && res.hresp_last)
            else stop_on_error($sformatf("%s at %h missed the two cycle ERROR", what, addr));
    endtask

    // Run limit of roughly ten times the sequence length
    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                $display("Timeout: the sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
                $display("TEST FAILED");
                $fatal(1, "Simulation stopped by timeout");
            end
        end
    end

    // ======================================================================
    // Stimulus sequence
    // ======================================================================
    initial begin
        logic [AHB_DATA_W-1:0] data;
        logic [CCM_AW-1:0]     idx;
        logic [CCM_AW-1:0]     kept_idx;
        logic [CCM_AW-1:0]     idx_q [$];
        logic [NUM_INTR-1:0]   intr_exp;
        int unsigned           i;

        rst_n      = 1'b0;
        generic_in = '0;
        ahb_req    = '{haddr: '0, htrans: HTRANS_IDLE, hwrite: 1'b0, hsize: 3'b011,
                       hwdata: '0};
        repeat (2) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        assert (ahb_resp.hready === 1'b1 && ahb_resp.hresp === 1'b0)
            else stop_on_error("bus response after reset is not ready and OKAY");
        assert (intr === '0) else stop_on_error($sformatf("intr_o after reset is %h", intr));
        assert (generic_out === '0)
            else stop_on_error($sformatf("generic_output_o after reset is %h", generic_out));

        // DCCM writes seen through the ICCM alias, then the other way round
        for (i = 0; i < NUM_WORDS; i++) begin
            idx  = CCM_AW'(lfsr_next_bits(CCM_AW));
            data = lfsr_next_bits(AHB_DATA_W);
            store_and_check(dccm_addr(idx), data, "DCCM");
            mem_model[idx] = data;
            idx_q.push_back(idx);
        end
        foreach (idx_q[k]) load_and_compare(iccm_addr(idx_q[k]), mem_model[idx_q[k]], "ICCM");
        idx_q.delete();
        for (i = 0; i < NUM_WORDS; i++) begin
            idx  = CCM_AW'(lfsr_next_bits(CCM_AW));
            data = lfsr_next_bits(AHB_DATA_W);
            store_and_check(iccm_addr(idx), data, "ICCM");
            mem_model[idx] = data;
            idx_q.push_back(idx);
        end
        foreach (idx_q[k]) load_and_compare(dccm_addr(idx_q[k]), mem_model[idx_q[k]], "DCCM");
        kept_idx = idx_q[0];

        // Generic wires
        data = lfsr_next_bits(GENERIC_W);
        store_and_check(reg_addr(REG_GENERIC_OUT), data, "generic out");
        @(negedge clk);
        assert (generic_out === data)
            else stop_on_error($sformatf("generic_output_o is %h, expected %h",
                                         generic_out, data));
        load_and_compare(reg_addr(REG_GENERIC_OUT), data, "generic out");
        @(posedge clk);
        #DRV_DLY;
        generic_in = lfsr_next_bits(GENERIC_W);
        load_and_compare(reg_addr(REG_GENERIC_IN), generic_in, "generic in");

        // Doorbell and notification interrupt
        store_and_check(reg_addr(REG_DOORBELL), lfsr_next_bits(AHB_DATA_W), "doorbell");
        @(negedge clk);
        assert (intr[NOTIF_BIT] === 1'b1) else stop_on_error("doorbell did not raise notif");
        load_and_compare(reg_addr(REG_NOTIF_STATUS), 64'd1, "notif status");
        load_and_compare(reg_addr(REG_DOORBELL), 64'd0, "doorbell");
        store_and_check(reg_addr(REG_NOTIF_STATUS), 64'd1, "notif clear");
        @(negedge clk);
        assert (intr[NOTIF_BIT] === 1'b0) else stop_on_error("notif interrupt not cleared");

        // ICCM lock
        store_and_check(reg_addr(REG_ICCM_LOCK), 64'd1, "lock");
        load_and_compare(reg_addr(REG_ICCM_LOCK), 64'd1, "lock");
        expect_bus_error(iccm_addr(kept_idx), 1'b1, "locked ICCM write");
        assert (intr[ERR_BIT] === 1'b1) else stop_on_error("blocked write did not raise error");
        store_and_check(reg_addr(REG_ERROR_STATUS), 64'd1, "error clear");
        @(negedge clk);
        assert (intr[ERR_BIT] === 1'b0) else stop_on_error("error interrupt not cleared");
        expect_bus_error(iccm_addr(kept_idx), 1'b0, "locked ICCM read");
        assert (intr[ERR_BIT] === 1'b1) else stop_on_error("blocked read did not raise error");
        load_and_compare(dccm_addr(kept_idx), mem_model[kept_idx], "DCCM after block");
        idx  = CCM_AW'(lfsr_next_bits(CCM_AW));
        data = lfsr_next_bits(AHB_DATA_W);
        store_and_check(dccm_addr(idx), data, "DCCM while locked");
        mem_model[idx] = data;
        load_and_compare(dccm_addr(idx), mem_model[idx], "DCCM while locked");
        store_and_check(reg_addr(REG_ERROR_STATUS), 64'd1, "error clear");
        @(negedge clk);
        assert (intr[ERR_BIT] === 1'b0) else stop_on_error("error interrupt not cleared");

        // Unmapped addresses with a pending notif to watch
        store_and_check(reg_addr(REG_DOORBELL), 64'd0, "doorbell");
        intr_exp = NUM_INTR'(1) << NOTIF_BIT;   // Only the doorbell pending
        @(negedge clk);
        assert (intr === intr_exp)
            else stop_on_error($sformatf("intr_o is %h before unmapped access, expected %h",
                                         intr, intr_exp));
        expect_bus_error(32'h6000_0000, 1'b0, "unmapped read");
        assert (intr === intr_exp) else stop_on_error("unmapped read changed intr_o");
        expect_bus_error(SOC_IFC_BASE + 32'h100, 1'b1, "unmapped write");
        @(negedge clk);
        assert (intr === intr_exp) else stop_on_error("unmapped write changed intr_o");
        store_and_check(reg_addr(REG_NOTIF_STATUS), 64'd1, "notif clear");

        $display("TEST PASSED");
        $finish;
    end

endmodule
